//--- filelist.f
common/cnn_pkg.sv
hdl/kernel_buffer.sv
hdl/inst_sequencer.sv
conv_pe/conv_pe.sv
hdl/result_sender.sv
hdl/cnn_top.sv
test/tb_cnn_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_cnn_top -f filelist.f -o tb_cnn_top

./obj_dir/tb_cnn_top | tee sim.log

if grep -qx "sim passed" sim.log; then
	exit 0
fi
echo "Pass line not found in sim.log"
exit 1

//--- test/tb_cnn_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cnn_top import cnn_pkg::*; ();

localparam int CREDITS   = 4;
localparam int RES_DEPTH = 4;
localparam int TIMEOUT   = 2000;   // Cycles per wait

logic     clk = 1'b0;
logic     rst_n;
inst_t    inst;
logic     inst_empty;
logic     inst_req;
tap_vec_t ddr_fifo_data;
logic     ddr_fifo_empty;
logic     ddr_fifo_req;
tap_vec_t feat_data;
logic     feat_empty;
logic     feat_req;
logic     res_valid;
res_t     res_data;
logic     res_credit;

inst_t    inst_q [$];
tap_vec_t ker_q [$];
tap_vec_t feat_q [$];
res_t     exp_q [$];
res_t     got_q [$];

tap_vec_t                 ker_m [4];   // Kernels as the model sees them
logic signed [BIAS_W-1:0] bias_m [4];
logic [15:0]              lfsr;
logic                     hold_credits;
int                       owed;        // Credits spent and not yet returned
int                       errors;
int                       tests;

cnn_top #(.CREDITS(CREDITS), .RES_DEPTH(RES_DEPTH)) DUT (.*);

always #5 clk = ~clk;

////////////////////////////////////////////////////////////////////////////
// Random data and reference model
////////////////////////////////////////////////////////////////////////////

// x^16 + x^14 + x^13 + x^11 + 1
function automatic logic lfsr_bit();
	logic fb;
	fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
	lfsr = {lfsr[14:0], fb};
	return fb;
endfunction

function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++)
		v = {v[30:0], lfsr_bit()};
	return v;
endfunction

function automatic tap_vec_t rand_taps();
	tap_vec_t t;
	for (int i = 0; i < KER_TAPS; i++)
		t[i] = tap_t'(rand_bits(TAP_W));
	return t;
endfunction

function automatic res_t model_res(input tap_vec_t win, input int slot, input int shift,
		input logic relu);
	int acc;
	acc = int'(bias_m[slot]);
	for (int i = 0; i < KER_TAPS; i++)
		acc += int'($signed(win[i])) * int'($signed(ker_m[slot][i]));
	acc = acc >>> shift;
	if (relu && acc < 0)
		acc = 0;   // ReLU
	return res_t'(acc);
endfunction

////////////////////////////////////////////////////////////////////////////
// FIFO models and credit return
////////////////////////////////////////////////////////////////////////////

initial begin
	logic ireq;
	logic kreq;
	logic freq;
	forever begin
		@(negedge clk);   // Requests and results are stable here
		ireq = inst_req;
		kreq = ddr_fifo_req;
		freq = feat_req;
		if (res_valid) begin
			got_q.push_back(res_data);
			owed++;
		end
		@(posedge clk);
		#1;
		if (ireq)
			inst = inst_q.pop_front();
		if (kreq)
			ddr_fifo_data = ker_q.pop_front();
		if (freq)
			feat_data = feat_q.pop_front();
		inst_empty     = (inst_q.size() == 0);
		ddr_fifo_empty = (ker_q.size() == 0);
		feat_empty     = (feat_q.size() == 0);
		res_credit     = (owed > 0) && !hold_credits;
		if (res_credit)
			owed--;
	end
end

////////////////////////////////////////////////////////////////////////////
// Checks, waits and stimulus
////////////////////////////////////////////////////////////////////////////

task automatic check_res(input string name, input res_t exp, input res_t act);
	if (act !== exp) begin
		$display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
		errors++;
	end
endtask

task automatic check_count(input string name, input int exp, input int act);
	if (act != exp) begin
		$display("[FAIL] %s: expected count %0d, actual %0d", name, exp, act);
		errors++;
	end
endtask

task automatic wait_results(input string name, input int n);
	int cycles;
	cycles = 0;
	while (got_q.size() < n && cycles < TIMEOUT) begin
		@(posedge clk);
		cycles++;
	end
	if (got_q.size() < n) begin
		$display("%s: timed out waiting for %0d results, only %0d arrived", name, n,
			got_q.size());
		errors++;
	end
endtask

task automatic wait_drained(input string name);
	int cycles;
	cycles = 0;
	while ((inst_q.size() + ker_q.size() + feat_q.size()) != 0 && cycles < TIMEOUT) begin
		@(posedge clk);
		cycles++;
	end
	if ((inst_q.size() + ker_q.size() + feat_q.size()) != 0) begin
		$display("%s: timed out, the DUT stopped reading its input FIFOs", name);
		errors++;
	end
endtask

// Results must match the model in order and in number
task automatic compare_results(input string name);
	check_count(name, exp_q.size(), got_q.size());
	while (exp_q.size() > 0 && got_q.size() > 0)
		check_res(name, exp_q.pop_front(), got_q.pop_front());
	exp_q.delete();
	got_q.delete();
endtask

task automatic report(input string name, input int err0);
	tests++;
	if (errors == err0)
		$display("[PASS] %s", name);
	else
		$display("[FAIL] %s: %0d errors", name, errors - err0);
endtask

task automatic load_kernel(input int slot, input tap_vec_t taps,
		input logic signed [BIAS_W-1:0] bias);
	inst_t w;
	w = '0;
	w.ld.opcode  = OP_LOAD;
	w.ld.slot    = SLOT_W'(slot);
	w.ld.bias    = bias;
	ker_m[slot]  = taps;
	bias_m[slot] = bias;
	ker_q.push_back(taps);
	inst_q.push_back(w);
endtask

task automatic conv_windows(input int slot, input int n, input int shift, input logic relu);
	inst_t    w;
	tap_vec_t win;
	w = '0;
	w.cv.opcode = OP_CONV;
	w.cv.slot   = SLOT_W'(slot);
	w.cv.count  = WIN_CNT_W'(n);
	w.cv.shift  = SHIFT_W'(shift);
	w.cv.relu   = relu;
	for (int i = 0; i < n; i++) begin
		win = rand_taps();
		feat_q.push_back(win);
		exp_q.push_back(model_res(win, slot, shift, relu));
	end
	inst_q.push_back(w);
endtask

task automatic unknown_inst(input logic [1:0] op);
	inst_t w;
	w = inst_t'(rand_bits(INST_LEN));
	w.ld.opcode = op;
	inst_q.push_back(w);
endtask

////////////////////////////////////////////////////////////////////////////
// Directed tests
////////////////////////////////////////////////////////////////////////////

task automatic test_reset();
	int err0;
	int high;
	err0 = errors;
	high = 0;
	repeat (20) begin
		@(negedge clk);
		if (inst_req || ddr_fifo_req || feat_req || res_valid)
			high++;
	end
	check_count("reset", 0, high);
	report("reset", err0);
endtask

task automatic test_single();
	int err0;
	err0 = errors;
	load_kernel(1, rand_taps(), BIAS_W'(rand_bits(BIAS_W)));
	conv_windows(1, 1, 0, 1'b0);
	wait_results("single", 1);
	compare_results("single");
	report("single", err0);
endtask

task automatic test_many();
	int err0;
	err0 = errors;
	conv_windows(1, 20, 1 + int'(rand_bits(2)), 1'b1);
	wait_results("many", 20);
	compare_results("many");
	report("many", err0);
endtask

task automatic test_credits();
	int err0;
	err0 = errors;
	@(posedge clk);
	hold_credits = 1'b1;
	conv_windows(1, 10, int'(rand_bits(3)), 1'b0);
	wait_results("credits", CREDITS);
	repeat (20) @(posedge clk);   // Nothing more may leave without credits
	check_count("credits", CREDITS, got_q.size());
	hold_credits = 1'b0;
	wait_results("credits", 10);
	compare_results("credits");
	report("credits", err0);
endtask

task automatic test_slots();
	int err0;
	err0 = errors;
	load_kernel(0, rand_taps(), BIAS_W'(rand_bits(BIAS_W)));
	load_kernel(2, rand_taps(), BIAS_W'(rand_bits(BIAS_W)));
	conv_windows(0, 3, 1, 1'b0);
	unknown_inst(2'b11);
	conv_windows(2, 4, 2, 1'b1);
	unknown_inst(2'b00);
	conv_windows(2, 0, 0, 1'b0);   // Empty conv
	conv_windows(0, 2, 0, 1'b1);
	wait_results("slots", 9);
	wait_drained("slots");
	repeat (10) @(posedge clk);
	compare_results("slots");
	report("slots", err0);
endtask

initial begin
	inst           = '0;
	inst_empty     = 1'b1;
	ddr_fifo_data  = '0;
	ddr_fifo_empty = 1'b1;
	feat_data      = '0;
	feat_empty     = 1'b1;
	res_credit     = 1'b0;
	hold_credits   = 1'b0;
	owed           = 0;
	errors         = 0;
	tests          = 0;
	lfsr           = 16'd33108;
	rst_n          = 1'b0;
	repeat (10) @(posedge clk);
	#1 rst_n = 1'b1;

	test_reset();
	test_single();
	test_many();
	test_credits();
	test_slots();

	$display("tests %0d, errors %0d", tests, errors);
	if (errors == 0)
		$display("sim passed");
	else
		$display("sim failed");
	$finish;
end

endmodule

`default_nettype wire

//--- hdl/cnn_top.sv
`timescale 1ns/1ps
`default_nettype none

module cnn_top import cnn_pkg::*; #(
	parameter int CREDITS   = 4,
	parameter int RES_DEPTH = 4
) (
	input  wire logic     clk,
	input  wire logic     rst_n,

	// Instruction FIFO
	input  wire inst_t    inst,
	input  wire logic     inst_empty,
	output logic          inst_req,

	// Kernel stream from the DDR side
	input  wire tap_vec_t ddr_fifo_data,
	input  wire logic     ddr_fifo_empty,
	output logic          ddr_fifo_req,

	// Feature windows
	input  wire tap_vec_t feat_data,
	input  wire logic     feat_empty,
	output logic          feat_req,

	// Credit-counted result output
	output logic          res_valid,
	output res_t          res_data,
	input  wire logic     res_credit
);

logic                     room;
logic                     ker_we;
logic [SLOT_W-1:0]        ker_wr_slot;
logic signed [BIAS_W-1:0] ker_wr_bias;
logic [SLOT_W-1:0]        ker_rd_slot;
ker_entry_t               ker_rd_entry;
conv_ctl_t                conv_ctl;
logic                     res_push;
res_t                     pe_res;

inst_sequencer seq (
	.clk            (clk),
	.rst_n          (rst_n),
	.inst           (inst),
	.inst_empty     (inst_empty),
	.inst_req       (inst_req),
	.ddr_fifo_empty (ddr_fifo_empty),
	.ddr_fifo_req   (ddr_fifo_req),
	.feat_empty     (feat_empty),
	.feat_req       (feat_req),
	.room           (room),
	.ker_we         (ker_we),
	.ker_wr_slot    (ker_wr_slot),
	.ker_wr_bias    (ker_wr_bias),
	.ker_rd_slot    (ker_rd_slot),
	.conv_ctl       (conv_ctl)
);

kernel_buffer kb (
	.clk      (clk),
	.rst_n    (rst_n),
	.we       (ker_we),
	.wr_slot  (ker_wr_slot),
	.wr_entry ({ddr_fifo_data, ker_wr_bias}),   // Kernel word joined with its bias
	.rd_slot  (ker_rd_slot),
	.rd_entry (ker_rd_entry)
);

conv_pe pe (
	.clk      (clk),
	.rst_n    (rst_n),
	.ctl      (conv_ctl),
	.window   (feat_data),
	.entry    (ker_rd_entry),
	.res_push (res_push),
	.res      (pe_res)
);

result_sender #(
	.CREDITS   (CREDITS),
	.RES_DEPTH (RES_DEPTH)
) rs (
	.clk        (clk),
	.rst_n      (rst_n),
	.reserve    (feat_req),   // Every requested window will push one result
	.room       (room),
	.push       (res_push),
	.push_data  (pe_res),
	.res_valid  (res_valid),
	.res_data   (res_data),
	.res_credit (res_credit)
);

endmodule

`default_nettype wire

//--- hdl/result_sender.sv
`timescale 1ns/1ps
`default_nettype none

module result_sender import cnn_pkg::*; #(
	parameter int CREDITS   = 4,
	parameter int RES_DEPTH = 4
) (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire logic reserve,     // One slot per requested window
	output logic      room,
	input  wire logic push,
	input  wire res_t push_data,
	output logic      res_valid,
	output res_t      res_data,
	input  wire logic res_credit
);

localparam int PTR_W = (RES_DEPTH > 1) ? $clog2(RES_DEPTH) : 1;
localparam int CNT_W = $clog2(RES_DEPTH + 1);
localparam int CR_W  = $clog2(CREDITS + 1);

res_t             mem [RES_DEPTH];
logic [PTR_W-1:0] wr_ptr;
logic [PTR_W-1:0] rd_ptr;
logic [CNT_W-1:0] count;      // Results held in the queue
logic [CNT_W-1:0] reserved;   // Windows requested, result not yet pushed
logic [CR_W-1:0]  credits;
logic             pop;

function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
	return (p == PTR_W'(RES_DEPTH - 1)) ? '0 : p + 1'b1;
endfunction

assign pop       = (count != '0) && (credits != '0);
assign res_valid = pop;
assign res_data  = mem[rd_ptr];
assign room      = ({1'b0, count} + {1'b0, reserved}) < RES_DEPTH;

////////////////////////////////////////////////////////////////////////////
// Queue and counters
////////////////////////////////////////////////////////////////////////////

always_ff @(posedge clk) begin
	if (push)
		mem[wr_ptr] <= push_data;
end

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		wr_ptr   <= '0;
		rd_ptr   <= '0;
		count    <= '0;
		reserved <= '0;
		credits  <= CR_W'(CREDITS);
	end else begin
		if (push)
			wr_ptr <= ptr_inc(wr_ptr);
		if (pop)
			rd_ptr <= ptr_inc(rd_ptr);
		count    <= count + CNT_W'(push) - CNT_W'(pop);
		reserved <= reserved + CNT_W'(reserve) - CNT_W'(push);
		credits  <= credits + CR_W'(res_credit) - CR_W'(pop);   // One credit per result
	end
end

a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
	credits <= CREDITS);
a_valid_has_credit: assert property (@(posedge clk) disable iff (!rst_n)
	res_valid |-> credits != '0);
a_push_not_full: assert property (@(posedge clk) disable iff (!rst_n)
	push |-> count < RES_DEPTH);

endmodule

`default_nettype wire

//--- conv_pe/conv_pe.sv
`timescale 1ns/1ps
`default_nettype none

module conv_pe import cnn_pkg::*; (
	input  wire logic       clk,
	input  wire logic       rst_n,
	input  wire conv_ctl_t  ctl,
	input  wire tap_vec_t   window,
	input  wire ker_entry_t entry,
	output logic            res_push,
	output res_t            res
);

localparam int PROD_W = 2 * TAP_W;

// Stage 1 registers
logic                     valid1;
logic signed [PROD_W-1:0] prod1 [KER_TAPS];
logic signed [BIAS_W-1:0] bias1;
logic [SHIFT_W-1:0]       shift1;
logic                     relu1;

// Stage 2 registers
logic                     valid2;
logic signed [RES_W-1:0]  sum2;
logic [SHIFT_W-1:0]       shift2;
logic                     relu2;

logic signed [RES_W-1:0]  sum_nxt;
logic signed [RES_W-1:0]  shifted;

////////////////////////////////////////////////////////////////////////////
// Valid pipeline
////////////////////////////////////////////////////////////////////////////

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		valid1   <= 1'b0;
		valid2   <= 1'b0;
		res_push <= 1'b0;
	end else begin
		valid1   <= ctl.valid;
		valid2   <= valid1;
		res_push <= valid2;
	end
end

// Stage 1 captures nine products
always_ff @(posedge clk) begin
	if (ctl.valid) begin
		for (int i = 0; i < KER_TAPS; i++)
			prod1[i] <= $signed(window[i]) * $signed(entry.taps[i]);
		bias1  <= entry.bias;
		shift1 <= ctl.shift;
		relu1  <= ctl.relu;
	end
end

// Adder tree plus bias fits in RES_W without overflow
always_comb begin
	sum_nxt = bias1;
	for (int i = 0; i < KER_TAPS; i++)
		sum_nxt = sum_nxt + prod1[i];
end

// Stage 2
always_ff @(posedge clk) begin
	if (valid1) begin
		sum2   <= sum_nxt;
		shift2 <= shift1;
		relu2  <= relu1;
	end
end

assign shifted = sum2 >>> shift2;   // Arithmetic shift keeps the sign

// Stage 3 clamps negatives when relu is set
always_ff @(posedge clk) begin
	if (valid2)
		res <= (relu2 && shifted[RES_W-1]) ? '0 : shifted;
end

endmodule

`default_nettype wire

//--- hdl/inst_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module inst_sequencer import cnn_pkg::*; (
	input  wire logic                clk,
	input  wire logic                rst_n,
	input  wire inst_t               inst,
	input  wire logic                inst_empty,
	output logic                     inst_req,
	input  wire logic                ddr_fifo_empty,
	output logic                     ddr_fifo_req,
	input  wire logic                feat_empty,
	output logic                     feat_req,
	input  wire logic                room,
	output logic                     ker_we,
	output logic [SLOT_W-1:0]        ker_wr_slot,
	output logic signed [BIAS_W-1:0] ker_wr_bias,
	output logic [SLOT_W-1:0]        ker_rd_slot,
	output conv_ctl_t                conv_ctl
);

typedef enum logic [2:0] {
	S_IDLE,
	S_FETCH,    // Instruction word on inst this cycle
	S_DECODE,
	S_LOAD,     // Kernel word on ddr_fifo_data this cycle
	S_CONV
} state_t;

state_t               state;
state_t               state_nxt;
inst_t                inst_r;
logic [WIN_CNT_W-1:0] win_left;
logic [1:0]           op;

assign op = inst_r.ld.opcode;

// Load view drives the write side, conv view the read side
assign ker_we      = (state == S_LOAD);
assign ker_wr_slot = inst_r.ld.slot;
assign ker_wr_bias = inst_r.ld.bias;
assign ker_rd_slot = inst_r.cv.slot;

////////////////////////////////////////////////////////////////////////////
// Next state and FIFO requests
////////////////////////////////////////////////////////////////////////////

always_comb begin
	state_nxt    = state;
	inst_req     = 1'b0;
	ddr_fifo_req = 1'b0;
	feat_req     = 1'b0;
	case (state)
		S_IDLE: begin
			if (!inst_empty) begin
				inst_req  = 1'b1;
				state_nxt = S_FETCH;
			end
		end
		S_FETCH: state_nxt = S_DECODE;
		S_DECODE: begin
			case (op)
				OP_LOAD: begin
					if (!ddr_fifo_empty) begin
						ddr_fifo_req = 1'b1;
						state_nxt    = S_LOAD;
					end
				end
				OP_CONV: state_nxt = (inst_r.cv.count == '0) ? S_IDLE : S_CONV;
				default: state_nxt = S_IDLE;   // Unknown opcode, skip
			endcase
		end
		S_LOAD: state_nxt = S_IDLE;
		S_CONV: begin
			// One window per cycle while the output side has room
			if (!feat_empty && room) begin
				feat_req = 1'b1;
				if (win_left == WIN_CNT_W'(1))
					state_nxt = S_IDLE;
			end
		end
		default: state_nxt = S_IDLE;
	endcase
end

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		state    <= S_IDLE;
		inst_r   <= '0;
		win_left <= '0;
		conv_ctl <= '0;
	end else begin
		state <= state_nxt;
		if (state == S_FETCH)
			inst_r <= inst;
		if (state == S_DECODE)
			win_left <= inst_r.cv.count;
		else if (feat_req)
			win_left <= win_left - 1'b1;
		conv_ctl.valid <= feat_req;   // Window arrives one cycle after the request
		conv_ctl.shift <= inst_r.cv.shift;
		conv_ctl.relu  <= inst_r.cv.relu;
	end
end

a_feat_req_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
	feat_req |-> !feat_empty);

endmodule

`default_nettype wire

//--- hdl/kernel_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module kernel_buffer import cnn_pkg::*; (
	input  wire logic              clk,
	input  wire logic              rst_n,

	// Write port from a load instruction
	input  wire logic              we,
	input  wire logic [SLOT_W-1:0] wr_slot,
	input  wire ker_entry_t        wr_entry,

	// Slot selected by the current conv
	input  wire logic [SLOT_W-1:0] rd_slot,
	output ker_entry_t             rd_entry
);

localparam int SLOTS = 2 ** SLOT_W;

ker_entry_t slots [SLOTS];

////////////////////////////////////////////////////////////////////////////
// Slot storage
////////////////////////////////////////////////////////////////////////////

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		for (int i = 0; i < SLOTS; i++)
			slots[i] <= '0;
	end else if (we) begin
		slots[wr_slot] <= wr_entry;   // Kernel and bias written together
	end
end

// Read is combinational, PE stage 1 captures it with the window
assign rd_entry = slots[rd_slot];

endmodule

`default_nettype wire

//--- common/cnn_pkg.sv
`default_nettype none

package cnn_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////////////////////

	localparam int TAP_W     = 8;   // One kernel or feature tap
	localparam int KER_TAPS  = 9;   // 3x3 window
	localparam int BIAS_W    = 20;
	localparam int RES_W     = 24;
	localparam int SLOT_W    = 2;   // Four kernel slots
	localparam int SHIFT_W   = 5;
	localparam int INST_LEN  = 32;
	localparam int WIN_CNT_W = 16;  // Windows per conv instruction

	// Opcodes, anything else is skipped by the sequencer
	localparam logic [1:0] OP_LOAD = 2'b01;
	localparam logic [1:0] OP_CONV = 2'b10;

	////////////////////////////////////////////////////////////////////////////
	// Data types
	////////////////////////////////////////////////////////////////////////////

	typedef logic signed [TAP_W-1:0] tap_t;
	typedef tap_t [KER_TAPS-1:0] tap_vec_t;   // Kernel word or feature window

	typedef struct packed {
		logic [1:0]               opcode;
		logic [SLOT_W-1:0]        slot;
		logic signed [BIAS_W-1:0] bias;
		logic [7:0]               pad;
	} load_inst_t;

	typedef struct packed {
		logic [1:0]           opcode;
		logic [SLOT_W-1:0]    slot;
		logic [WIN_CNT_W-1:0] count;   // Zero means nothing to do
		logic [SHIFT_W-1:0]   shift;
		logic                 relu;
		logic [5:0]           pad;
	} conv_inst_t;

	// Opcode sits in the top two bits of both views
	typedef union packed {
		load_inst_t ld;
		conv_inst_t cv;
	} inst_t;

	typedef struct packed {
		tap_vec_t                 taps;
		logic signed [BIAS_W-1:0] bias;
	} ker_entry_t;

	typedef struct packed {
		logic               valid;
		logic [SHIFT_W-1:0] shift;
		logic               relu;
	} conv_ctl_t;

	typedef logic signed [RES_W-1:0] res_t;

endpackage

`default_nettype wire
